//--- logic/que_slot_pkg.sv
`default_nettype none

package que_slot_pkg;

    // One payload byte as stored in the slot
    typedef logic [7:0] byte_t;

    // Incoming byte, last flags the check byte closing the frame
    typedef struct packed {
        byte_t data;
        logic  last;
    } rx_beat_t;

    // FIFO read side, valid only in the cycle after a successful pop
    typedef struct packed {
        byte_t data;
        logic  valid;
    } fifo_rd_t;

    // Word pushed towards the queue, first marks the packet's first byte
    typedef struct packed {
        logic  first;
        byte_t data;
    } queue_word_t;

    typedef enum logic [2:0] {
        state_idle,
        state_advertise,
        state_push,
        state_wait_with_byte,
        state_wait
    } handler_state_t;

endpackage

`default_nettype wire

//--- logic/rx_frame_checker.sv
`timescale 1ns/1ns
`default_nettype none

module rx_frame_checker (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire que_slot_pkg::rx_beat_t rx_beat,
    input  wire                         rx_valid,
    input  wire                         fifo_empty,
    input  wire                         fifo_full,
    output logic                        wr_en,
    output que_slot_pkg::byte_t         wr_data,
    output logic                        good_packet,
    output logic                        bad_packet
);

    logic                in_frame;
    logic                accepting;
    logic                overflow;
    que_slot_pkg::byte_t xor_acc;
    que_slot_pkg::byte_t pending;

    logic                first_beat;
    logic                take_frame;
    logic                overflow_next;
    logic                frame_ok;
    que_slot_pkg::byte_t xor_next;

    ////////////////////
    // Beat decode

    assign first_beat    = rx_valid && !in_frame;
    // Frame is only taken when the slot was empty at its first beat
    assign take_frame    = first_beat ? fifo_empty : accepting;
    assign xor_next      = (first_beat ? 8'h00 : xor_acc) ^ rx_beat.data;
    assign overflow_next = overflow || (rx_valid && in_frame && fifo_full);

    // Needs at least one byte ahead of the check byte
    assign frame_ok = in_frame && (xor_next == 8'h00) && !overflow_next;

    // Pending byte goes out when the next beat proves it is not the check byte
    assign wr_en   = rx_valid && in_frame && accepting && !fifo_full;
    assign wr_data = pending;

    ////////////////////
    // Frame state and verdict

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            in_frame    <= 1'b0;
            accepting   <= 1'b0;
            overflow    <= 1'b0;
            good_packet <= 1'b0;
            bad_packet  <= 1'b0;
        end else begin
            good_packet <= 1'b0;
            bad_packet  <= 1'b0;
            if (rx_valid) begin
                if (rx_beat.last) begin
                    in_frame    <= 1'b0;
                    overflow    <= 1'b0;
                    good_packet <= take_frame && frame_ok;
                    bad_packet  <= take_frame && !frame_ok;
                end else begin
                    in_frame  <= 1'b1;
                    accepting <= take_frame;
                    overflow  <= overflow_next;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rx_valid) begin
            xor_acc <= xor_next;
            pending <= rx_beat.data;
        end
    end

    verdict_exclusive: assert property (
        @(posedge clock) disable iff (!reset_n) !(good_packet && bad_packet)
    ) else $error("good and bad verdict in the same cycle");

endmodule

`default_nettype wire

//--- logic/slot_byte_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module slot_byte_fifo #(
    parameter int ADDR_WIDTH = 4
) (
    input  wire                      clock,
    input  wire                      reset_n,
    input  wire                      fifo_reset_n,
    input  wire                      wr_en,
    input  wire que_slot_pkg::byte_t wr_data,
    input  wire                      pop,
    output que_slot_pkg::fifo_rd_t   rd,
    output logic                     empty,
    output logic                     full
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    que_slot_pkg::byte_t   mem [0:DEPTH-1];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;
    logic                  flush;
    logic                  do_write;
    logic                  do_pop;
    logic                  rd_valid;
    que_slot_pkg::byte_t   rd_data;

    // Either reset empties the slot
    assign flush = !reset_n || !fifo_reset_n;

    assign empty    = (count == '0);
    assign full     = (count == (ADDR_WIDTH + 1)'(DEPTH));
    assign do_write = wr_en && !full;
    assign do_pop   = pop && !empty;

    assign rd = '{data: rd_data, valid: rd_valid};

    ////////////////////
    // Pointers and fill level

    always_ff @(posedge clock) begin
        if (flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Empty pop reads back as no data
            rd_valid <= do_pop;
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////
    // Storage

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_pop) begin
            rd_data <= mem[rd_ptr];
        end
    end

    no_write_when_full: assert property (
        @(posedge clock) disable iff (!reset_n) !(wr_en && full)
    ) else $error("write request while the slot FIFO is full");

endmodule

`default_nettype wire

//--- logic/que_slot_receive_handler.sv
`timescale 1ns/1ns
`default_nettype none

module que_slot_receive_handler (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire                         enable,
    input  wire                         good_packet,
    input  wire                         bad_packet,
    input  wire                         push_data_enable,
    input  wire que_slot_pkg::fifo_rd_t rd,
    output logic                        fifo_reset_n,
    output logic                        ready,
    output logic                        push_data_ready,
    output que_slot_pkg::queue_word_t   push_data,
    output logic                        push_data_valid
);

    que_slot_pkg::handler_state_t state;
    que_slot_pkg::handler_state_t state_next;
    logic                         is_first_byte;
    logic                         is_first_byte_next;
    logic                         pop_d;
    que_slot_pkg::byte_t          parked;
    que_slot_pkg::byte_t          parked_next;
    logic                         emit;
    que_slot_pkg::byte_t          emit_byte;
    logic                         ready_next;
    logic                         push_data_ready_next;
    logic                         push_data_valid_next;
    logic                         fifo_reset_n_next;
    que_slot_pkg::queue_word_t    push_data_next;

    ////////////////////
    // Next state

    always_comb begin
        state_next           = state;
        is_first_byte_next   = is_first_byte;
        parked_next          = parked;
        emit                 = 1'b0;
        emit_byte            = rd.data;
        ready_next           = 1'b0;
        push_data_ready_next = 1'b0;
        fifo_reset_n_next    = 1'b1;

        case (state)
            que_slot_pkg::state_idle: begin
                is_first_byte_next = 1'b1;
                if (bad_packet) begin
                    fifo_reset_n_next = 1'b0;
                end else if (good_packet) begin
                    state_next = que_slot_pkg::state_advertise;
                end
            end
            que_slot_pkg::state_advertise: begin
                ready_next = 1'b1;
                if (enable && push_data_enable) begin
                    state_next           = que_slot_pkg::state_push;
                    push_data_ready_next = 1'b1;
                end
            end
            que_slot_pkg::state_push: begin
                push_data_ready_next = enable && push_data_enable;
                if (rd.valid) begin
                    // Popped while the queue still accepted
                    emit = 1'b1;
                    if (!push_data_enable) begin
                        state_next = que_slot_pkg::state_wait;
                    end
                end else if (pop_d) begin
                    // Pop came back empty so the packet is done
                    state_next           = que_slot_pkg::state_idle;
                    push_data_ready_next = 1'b0;
                end else if (!push_data_enable) begin
                    state_next = que_slot_pkg::state_wait;
                end
            end
            que_slot_pkg::state_wait: begin
                // Last pop issued before the withdrawal lands here
                if (rd.valid) begin
                    if (push_data_enable) begin
                        emit                 = 1'b1;
                        state_next           = que_slot_pkg::state_push;
                        push_data_ready_next = enable;
                    end else begin
                        parked_next = rd.data;
                        state_next  = que_slot_pkg::state_wait_with_byte;
                    end
                end else if (pop_d) begin
                    state_next = que_slot_pkg::state_idle;
                end else if (push_data_enable) begin
                    state_next           = que_slot_pkg::state_push;
                    push_data_ready_next = enable;
                end
            end
            que_slot_pkg::state_wait_with_byte: begin
                if (push_data_enable) begin
                    emit                 = 1'b1;
                    emit_byte            = parked;
                    state_next           = que_slot_pkg::state_push;
                    push_data_ready_next = enable;
                end
            end
            default: begin
                state_next = que_slot_pkg::state_idle;
            end
        endcase

        push_data_valid_next = emit;
        push_data_next       = push_data;
        if (emit) begin
            push_data_next     = '{first: is_first_byte, data: emit_byte};
            is_first_byte_next = 1'b0;
        end
    end

    ////////////////////
    // Registers

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state           <= que_slot_pkg::state_idle;
            is_first_byte   <= 1'b1;
            pop_d           <= 1'b0;
            ready           <= 1'b0;
            push_data_ready <= 1'b0;
            push_data_valid <= 1'b0;
            fifo_reset_n    <= 1'b0;
        end else begin
            state           <= state_next;
            is_first_byte   <= is_first_byte_next;
            pop_d           <= push_data_ready;
            ready           <= ready_next;
            push_data_ready <= push_data_ready_next;
            push_data_valid <= push_data_valid_next;
            fifo_reset_n    <= fifo_reset_n_next;
        end
    end

    always_ff @(posedge clock) begin
        parked    <= parked_next;
        push_data <= push_data_next;
    end

    // Words only come out of an active drain
    no_push_outside_drain: assert property (
        @(posedge clock) disable iff (!reset_n)
        $rose(push_data_valid) |->
            !(state inside {que_slot_pkg::state_idle, que_slot_pkg::state_advertise})
    ) else $error("push_data_valid rose outside of a drain");

endmodule

`default_nettype wire

//--- logic/que_slot_rx_top.sv
`timescale 1ns/1ns
`default_nettype none

module que_slot_rx_top #(
    parameter int ADDR_WIDTH = 4
) (
    input  wire                         clock,
    input  wire                         reset_n,
    input  wire que_slot_pkg::rx_beat_t rx_beat,
    input  wire                         rx_valid,
    input  wire                         enable,
    input  wire                         push_data_enable,
    output logic                        ready,
    output que_slot_pkg::queue_word_t   push_data,
    output logic                        push_data_valid,
    output logic                        push_data_ready
);

    logic                   wr_en;
    que_slot_pkg::byte_t    wr_data;
    logic                   fifo_empty;
    logic                   fifo_full;
    logic                   fifo_reset_n;
    logic                   good_packet;
    logic                   bad_packet;
    que_slot_pkg::fifo_rd_t rd;

    rx_frame_checker checker_i (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx_beat     (rx_beat),
        .rx_valid    (rx_valid),
        .fifo_empty  (fifo_empty),
        .fifo_full   (fifo_full),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .good_packet (good_packet),
        .bad_packet  (bad_packet)
    );

    // Pop is the handler's push_data_ready register
    slot_byte_fifo #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) fifo_i (
        .clock        (clock),
        .reset_n      (reset_n),
        .fifo_reset_n (fifo_reset_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .pop          (push_data_ready),
        .rd           (rd),
        .empty        (fifo_empty),
        .full         (fifo_full)
    );

    que_slot_receive_handler handler_i (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .good_packet      (good_packet),
        .bad_packet       (bad_packet),
        .push_data_enable (push_data_enable),
        .rd               (rd),
        .fifo_reset_n     (fifo_reset_n),
        .ready            (ready),
        .push_data_ready  (push_data_ready),
        .push_data        (push_data),
        .push_data_valid  (push_data_valid)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 2
) (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    // Synchronous reset held over the first rising edges
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- tests/que_slot_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module que_slot_rx_tb;

    localparam int CLOCK_PERIOD    = 40;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 400;

    logic                      clock;
    logic                      reset_n;
    que_slot_pkg::rx_beat_t    rx_beat;
    logic                      rx_valid;
    logic                      enable;
    logic                      push_data_enable;
    logic                      ready;
    que_slot_pkg::queue_word_t push_data;
    logic                      push_data_valid;
    logic                      push_data_ready;

    integer                    seed = 32'h34c6;
    que_slot_pkg::byte_t       payload [$];
    que_slot_pkg::byte_t       expected [$];
    que_slot_pkg::queue_word_t collected [$];

    tb_clock_gen #(
        .PERIOD       (CLOCK_PERIOD),
        .RESET_CYCLES (2)
    ) clock_gen_i (
        .clock   (clock),
        .reset_n (reset_n)
    );

    que_slot_rx_top #(
        .ADDR_WIDTH (4)
    ) dut_i (
        .clock            (clock),
        .reset_n          (reset_n),
        .rx_beat          (rx_beat),
        .rx_valid         (rx_valid),
        .enable           (enable),
        .push_data_enable (push_data_enable),
        .ready            (ready),
        .push_data        (push_data),
        .push_data_valid  (push_data_valid),
        .push_data_ready  (push_data_ready)
    );

    // Queue side, words taken mid-cycle where outputs are settled
    always @(negedge clock) begin
        if (reset_n && push_data_valid) begin
            collected.push_back(push_data);
        end
    end

    ////////////////////
    // Helpers

    task automatic check_equal(input string what, input logic [31:0] actual,
                               input logic [31:0] wanted);
        assert (actual === wanted) else begin
            $display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, actual, wanted);
            $display("TEST RESULT: FAIL");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic make_payload(input int length);
        payload.delete();
        for (int i = 0; i < length; i++) begin
            payload.push_back(8'($random(seed)));
        end
    endtask

    // Check byte rule: XOR over every payload byte
    function automatic que_slot_pkg::byte_t frame_check_byte();
        que_slot_pkg::byte_t acc;
        acc = 8'h00;
        foreach (payload[i]) begin
            acc ^= payload[i];
        end
        return acc;
    endfunction

    task automatic send_frame(input que_slot_pkg::byte_t corrupt);
        foreach (payload[i]) begin
            @(posedge clock);
            rx_valid <= 1'b1;
            rx_beat  <= '{data: payload[i], last: 1'b0};
        end
        @(posedge clock);
        rx_beat <= '{data: frame_check_byte() ^ corrupt, last: 1'b1};
        @(posedge clock);
        rx_valid <= 1'b0;
        rx_beat  <= '0;
        // Idle gap before the next frame
        repeat (4) @(posedge clock);
    endtask

    task automatic expect_slot_quiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clock);
            check_equal("ready", ready, 32'd0);
            check_equal("push_data_valid", push_data_valid, 32'd0);
            check_equal("push_data_ready", push_data_ready, 32'd0);
        end
    endtask

    task automatic drain_and_compare(input bit toggle_queue);
        int quiet;
        while (ready !== 1'b1) begin
            @(negedge clock);
        end
        @(posedge clock);
        enable           <= 1'b1;
        push_data_enable <= 1'b1;
        while (collected.size() < expected.size()) begin
            @(posedge clock);
            if (toggle_queue) begin
                push_data_enable <= 1'($random(seed));
            end
        end
        push_data_enable <= 1'b1;
        // Done once ready and push_data_ready both stay low
        quiet = 0;
        while (quiet < 4) begin
            @(negedge clock);
            if (ready || push_data_ready) begin
                quiet = 0;
            end else begin
                quiet++;
            end
        end
        @(posedge clock);
        enable           <= 1'b0;
        push_data_enable <= 1'b0;
        check_equal("delivered word count", collected.size(), expected.size());
        foreach (expected[i]) begin
            check_equal($sformatf("word %0d", i), 32'(collected[i]),
                        {23'd0, 1'(i == 0), expected[i]});
        end
        collected.delete();
    endtask

    ////////////////////
    // Directed tests

    task automatic reset_idle_outputs();
        expect_slot_quiet(10);
    endtask

    task automatic good_frame_drain();
        make_payload(10);
        send_frame(8'h00);
        expected = payload;
        drain_and_compare(1'b0);
    endtask

    task automatic bad_frame_flush();
        make_payload(9);
        send_frame(8'h5a);
        expect_slot_quiet(12);
        // Only this packet may come out after the flush
        make_payload(6);
        send_frame(8'h00);
        expected = payload;
        drain_and_compare(1'b0);
    endtask

    task automatic toggled_queue_drain();
        make_payload(14);
        send_frame(8'h00);
        expected = payload;
        drain_and_compare(1'b1);
    endtask

    task automatic busy_slot_drop();
        make_payload(8);
        send_frame(8'h00);
        expected = payload;
        // Slot still holds a packet, this frame vanishes
        make_payload(5);
        send_frame(8'h00);
        @(negedge clock);
        check_equal("ready while holding", ready, 32'd1);
        drain_and_compare(1'b0);
        expect_slot_quiet(12);
        // Valid check byte, but one byte more than the FIFO holds
        make_payload(17);
        send_frame(8'h00);
        expect_slot_quiet(12);
        make_payload(4);
        send_frame(8'h00);
        expected = payload;
        drain_and_compare(1'b0);
    endtask

    ////////////////////
    // Sequence and watchdog

    initial begin
        rx_beat          = '0;
        rx_valid         = 1'b0;
        enable           = 1'b0;
        push_data_enable = 1'b0;
        wait (reset_n === 1'b1);
        @(posedge clock);
        reset_idle_outputs();
        good_frame_drain();
        bad_frame_flush();
        toggled_queue_drain();
        busy_slot_drop();
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLOCK_PERIOD);
        $display("Watchdog timeout: the tests did not finish within %0d cycles",
                 NUM_TESTS * CYCLES_PER_TEST);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- compile.f
logic/que_slot_pkg.sv
logic/rx_frame_checker.sv
logic/slot_byte_fifo.sv
logic/que_slot_receive_handler.sv
logic/que_slot_rx_top.sv
tests/tb_clock_gen.sv
tests/que_slot_rx_tb.sv

//--- Bender.yml
package:
  name: que_slot_rx

sources:
  - logic/que_slot_pkg.sv
  - logic/rx_frame_checker.sv
  - logic/slot_byte_fifo.sv
  - logic/que_slot_receive_handler.sv
  - logic/que_slot_rx_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/que_slot_rx_tb.sv
